// ==== fifo_buf.sv ====
`timescale 1ns/1ps

module fifo_buf import uart_rx_pkg::*; #(
	parameter int ADDR_W = FIFO_ADDR_W
) (
	input	logic		clk,
	input	logic		reset,
	input	logic		clear,
	input	logic		wena,
	input	rx_word_t	wdata,
	input	logic		rena,
	output	rx_word_t	rdata,
	output	fill_t		size,
	output	logic		empty,
	output	logic		full
);

	rx_word_t			mem [2**ADDR_W];
	logic [ADDR_W-1:0]	wr_ptr;
	logic [ADDR_W-1:0]	rd_ptr;
	logic [ADDR_W:0]	count;
	logic				do_wr;
	logic				do_rd;

	assign empty = (count == '0);
	// count never exceeds the depth, so the top bit alone marks full
	assign full = count[ADDR_W];
	assign size = fill_t'(count);
	assign do_wr = wena && !full;
	assign do_rd = rena && !empty;

	// show-ahead read of the oldest entry
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f uart_rx_hub.f --top-module tb_uart_rx_hub -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== tb_uart_rx_hub.sv ====
`timescale 1ns/1ps

module tb_uart_rx_hub
	import uart_line_pkg::*, uart_rx_pkg::*;
();

	localparam int MAX_STEPS = 64;
	localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_W;
	localparam logic [31:0] SEED = 32'h165b6bc3;

	// 8N1, flow control off, 16 cycles per bit
	localparam line_cfg_t RESET_SETTING = 28'h1000010;

	localparam logic [3:0] FAULT_PARITY = 4'd1;
	localparam logic [3:0] FAULT_STOP = 4'd2;
	localparam logic [3:0] FAULT_GLITCH = 4'd3;

	// one line of the data file
	typedef struct packed {
		line_cfg_t	cfg;
		logic [3:0]	ctrl;
		logic [3:0]	mask;
		logic [7:0]	data;
		logic [3:0]	fault;
		logic [3:0]	hold;
		logic [3:0]	flags;
	} step_t;

	logic					clk;
	logic					reset;
	logic					cfg_we;
	line_cfg_t				cfg_wdata;
	logic	[NUM_CHAN-1:0]	rx;
	logic	[NUM_CHAN-1:0]	rts;
	logic					hold;
	logic					out_valid;
	rx_rec_t				out_rec;

	logic [55:0]			step_mem [MAX_STEPS];
	rx_rec_t				exp_q [NUM_CHAN][$];
	logic [NUM_CHAN-1:0]	ovf_pend;
	line_cfg_t				cur_cfg;
	int						cur_div;
	int						errors;
	int						checks;
	longint					watch_ns;
	// hold as the drain saw it on the edge that formed the current output
	logic					hold_last;

	uart_rx_hub u_uart_rx_hub (
		.clk(clk),
		.reset(reset),
		.cfg_we(cfg_we),
		.cfg_wdata(cfg_wdata),
		.rx(rx),
		.rts(rts),
		.hold(hold),
		.out_valid(out_valid),
		.out_rec(out_rec)
	);

	always #4 clk = ~clk;

	task automatic compare_field(string name, int chan, int got, int want);
		checks++;
		if (got != want) begin
			errors++;
			$display("MISMATCH at %0t ns: channel %0d %s is %0h, expected %0h",
				$time, chan, name, got, want);
		end
	endtask

	// every output record must match the oldest expected record of its channel
	task automatic check_output();
		rx_rec_t	want;
		int			ch;
		if (out_valid && hold_last) begin
			errors++;
			$display("record came out at %0t ns although hold was high", $time);
		end
		if (out_valid) begin
			ch = int'(out_rec.chan);
			if (exp_q[ch].size() == 0) begin
				errors++;
				$display("unexpected record at %0t ns on channel %0d, data %0h",
					$time, ch, out_rec.word.data);
			end else begin
				want = exp_q[ch].pop_front();
				want.overflow = ovf_pend[ch];
				ovf_pend[ch] = 1'b0;
				compare_field("data", ch, int'(out_rec.word.data), int'(want.word.data));
				compare_field("noise", ch, int'(out_rec.word.noise), int'(want.word.noise));
				compare_field("parity", ch, int'(out_rec.word.parity), int'(want.word.parity));
				compare_field("frame", ch, int'(out_rec.word.frame), int'(want.word.frame));
				compare_field("overflow", ch, int'(out_rec.overflow), int'(want.overflow));
			end
		end
	endtask

	// outputs are looked at on the falling edge, inputs change 1 ns after the rising edge
	task automatic cycle();
		@(negedge clk);
		check_output();
		hold_last = hold;
		@(posedge clk);
		#1;
	endtask

	function automatic logic queues_pending();
		logic busy;
		busy = 1'b0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (exp_q[c].size() != 0)
				busy = 1'b1;
		end
		return busy;
	endfunction

	function automatic int frame_len(line_cfg_t cfg);
		return 1 + (cfg.data_bits ? 8 : 7) + (cfg.parity ? 1 : 0) + (cfg.stop_bits ? 2 : 1);
	endfunction

	// line level of each bit slot, start bit in slot 0, idle high past the frame
	function automatic logic [15:0] frame_bits(logic [7:0] data, logic [3:0] fault,
		line_cfg_t cfg);
		logic [15:0]	bits;
		int				nbits;
		int				pos;
		logic			par;
		bits = '1;
		bits[0] = 1'b0;
		nbits = cfg.data_bits ? 8 : 7;
		par = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			bits[1 + i] = data[i];
			par ^= data[i];
		end
		pos = 1 + nbits;
		if (cfg.parity) begin
			// even parity
			bits[pos] = (fault == FAULT_PARITY) ? !par : par;
			pos++;
		end
		if (fault == FAULT_STOP) begin
			bits[pos] = 1'b0;
			if (cfg.stop_bits)
				bits[pos + 1] = 1'b0;
		end
		return bits;
	endfunction

	// all masked channels send together, followed by one idle bit time
	task automatic send_frames(logic [3:0] mask, logic [NUM_CHAN-1:0][7:0] bytes,
		logic [3:0] fault);
		logic [NUM_CHAN-1:0][15:0]	bits;
		int							nslots;
		for (int c = 0; c < NUM_CHAN; c++)
			bits[c] = frame_bits(bytes[c], fault, cur_cfg);
		nslots = frame_len(cur_cfg) + 1;
		for (int s = 0; s < nslots; s++) begin
			for (int t = 0; t < cur_div; t++) begin
				for (int c = 0; c < NUM_CHAN; c++) begin
					if (mask[c]) begin
						rx[c] = bits[c][s];
						// one cycle flipped on the middle sample of data bit 2
						if (fault == FAULT_GLITCH && s == 3 && t == cur_div / 2)
							rx[c] = !bits[c][s];
					end
				end
				cycle();
			end
		end
	endtask

	task automatic push_expected(logic [3:0] mask, logic [NUM_CHAN-1:0][7:0] bytes,
		logic [3:0] flags);
		rx_rec_t rec;
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (mask[c]) begin
				rec.chan = chan_id_t'(c);
				rec.word.data = cur_cfg.data_bits ? bytes[c] : {1'b0, bytes[c][6:0]};
				rec.word.noise = flags[2];
				rec.word.parity = flags[1];
				rec.word.frame = flags[0];
				rec.overflow = 1'b0;
				// a full FIFO drops the word and marks the next record read
				if (exp_q[c].size() < FIFO_DEPTH)
					exp_q[c].push_back(rec);
				else
					ovf_pend[c] = 1'b1;
			end
		end
	endtask

	task automatic write_cfg(line_cfg_t setting);
		cfg_wdata = setting;
		cfg_we = 1'b1;
		cycle();
		cfg_we = 1'b0;
		// clear follows one cycle after the write
		cycle();
		cycle();
		cur_cfg = setting;
		cur_div = (setting.baud_div < BAUD_MIN) ? int'(BAUD_MIN) : int'(setting.baud_div);
		for (int c = 0; c < NUM_CHAN; c++)
			exp_q[c].delete();
	endtask

	// also gives records that should not exist time to show up
	task automatic wait_drained();
		int waited;
		int limit;
		int settle;
		waited = 0;
		limit = 2 * cur_div + 2 * NUM_CHAN * FIFO_DEPTH;
		settle = NUM_CHAN * FIFO_DEPTH + 4;
		while ((queues_pending() || waited < settle) && waited < limit) begin
			cycle();
			waited++;
		end
		if (queues_pending()) begin
			errors++;
			$display("expected records never came out, gave up at %0t ns", $time);
			for (int c = 0; c < NUM_CHAN; c++)
				exp_q[c].delete();
		end
	endtask

	task automatic check_rts();
		logic [NUM_CHAN-1:0] want;
		for (int c = 0; c < NUM_CHAN; c++)
			want[c] = cur_cfg.flow_ctrl && (exp_q[c].size() > int'(RTS_LEVEL));
		checks++;
		if (rts != want) begin
			errors++;
			$display("MISMATCH at %0t ns: rts is %b, expected %b", $time, rts, want);
		end
	endtask

	initial begin
		step_t						step;
		logic [NUM_CHAN-1:0][7:0]	bytes;
		int							nsteps;
		int							max_div;
		int							div;
		clk = 1'b0;
		reset = 1'b1;
		cfg_we = 1'b0;
		cfg_wdata = RESET_SETTING;
		rx = '1;
		hold = 1'b0;
		hold_last = 1'b0;
		errors = 0;
		checks = 0;
		ovf_pend = '0;
		watch_ns = 0;
		cur_cfg = RESET_SETTING;
		cur_div = int'(BAUD_MIN);
		void'($urandom(SEED));

		for (int i = 0; i < MAX_STEPS; i++)
			step_mem[i] = '1;
		$readmemh("uart_rx_hub_testdata.txt", step_mem);
		nsteps = 0;
		max_div = int'(BAUD_MIN);
		while (nsteps < MAX_STEPS && step_mem[nsteps] != '1) begin
			step = step_t'(step_mem[nsteps]);
			div = int'(step.cfg.baud_div);
			if (div > max_div)
				max_div = div;
			nsteps++;
		end
		if (nsteps == 0) begin
			errors++;
			$display("no test steps found in uart_rx_hub_testdata.txt");
		end
		watch_ns = longint'(nsteps) * 12 * max_div * 8 * 4;

		repeat (8) cycle();
		reset = 1'b0;
		cycle();
		check_rts();

		for (int i = 0; i < nsteps; i++) begin
			step = step_t'(step_mem[i]);
			if (step.ctrl[0] || step.cfg != cur_cfg)
				write_cfg(step.cfg);
			hold = step.hold[0];
			if (!step.ctrl[2]) begin
				for (int c = 0; c < NUM_CHAN; c++)
					bytes[c] = step.ctrl[1] ? 8'($urandom) : step.data;
				push_expected(step.mask, bytes, step.flags);
				send_frames(step.mask, bytes, step.fault);
			end
			if (!hold)
				wait_drained();
			check_rts();
		end

		$display("fields checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// bound on the whole run, armed once the steps are counted
	initial begin
		wait (watch_ns != 0);
		#(watch_ns);
		$display("timeout, the run was still busy after %0d ns", watch_ns);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== uart_line_cfg.sv ====
`timescale 1ns/1ps

module uart_line_cfg import uart_line_pkg::*; (
	input	logic		clk,
	input	logic		reset,
	input	logic		cfg_we,
	input	line_cfg_t	cfg_wdata,
	output	line_cfg_t	cfg,
	output	logic		clear
);

	line_cfg_t	cfg_clamped;

	always_comb begin
		cfg_clamped = cfg_wdata;
		// slower than the sample offsets allow is fine, faster is not
		if (cfg_wdata.baud_div < BAUD_MIN)
			cfg_clamped.baud_div = BAUD_MIN;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			cfg <= CFG_RESET;
			clear <= 1'b0;
		end else begin
			if (cfg_we)
				cfg <= cfg_clamped;
			// one-cycle flush of every channel after a new setting
			clear <= cfg_we;
		end
	end

endmodule

// ==== uart_line_pkg.sv ====
package uart_line_pkg;

	// receiver channels sharing one line setting
	localparam int NUM_CHAN = 4;
	localparam int CHAN_W = $clog2(NUM_CHAN);

	typedef logic [CHAN_W-1:0] chan_id_t;

	// clock cycles per bit
	typedef logic [23:0] baud_div_t;

	// below this the sixteenth-bit sample offsets collapse onto the middle sample
	localparam baud_div_t BAUD_MIN = 24'd16;

	typedef struct packed {
		logic		flow_ctrl;
		logic		parity;
		// 1 selects two stop bits
		logic		stop_bits;
		// 1 selects 8 data bits, 0 selects 7
		logic		data_bits;
		baud_div_t	baud_div;
	} line_cfg_t;

	// 8N1 at the fastest allowed rate, flow control off
	localparam line_cfg_t CFG_RESET = '{
		flow_ctrl: 1'b0,
		parity:    1'b0,
		stop_bits: 1'b0,
		data_bits: 1'b1,
		baud_div:  BAUD_MIN
	};

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_line_pkg::*; import uart_rx_pkg::*; (
	input	logic		clk,
	input	logic		reset,
	input	logic		clear,
	input	logic		rx,
	input	line_cfg_t	cfg,
	input	logic		rena,
	output	rx_word_t	head,
	output	logic		empty,
	output	logic		rts,
	output	logic		overflow
);

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

	rx_state_t	state;
	logic [1:0]	rx_sync;
	logic		rx_s;
	baud_div_t	cnt;
	baud_div_t	half;
	baud_div_t	sixteenth;
	logic		bit_end;
	logic [2:0]	samples;
	logic		vote;
	logic		split;
	logic [2:0]	bit_idx;
	logic		last_data;
	logic		stop_idx;
	logic [7:0]	shreg;
	logic		noise_acc;
	logic		parity_acc;
	logic		frame_acc;
	logic		wena;
	rx_word_t	wword;
	logic		full;
	fill_t		size;

	// two-flop synchronizer, idles high like the line
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rx};
	end

	assign rx_s = rx_sync[1];

	assign half = cfg.baud_div >> 1;
	assign sixteenth = cfg.baud_div >> 4;
	assign bit_end = (cnt == cfg.baud_div - 24'd1);

	// majority of the three samples, and whether they disagree at all
	assign vote = (samples[0] & samples[1]) | (samples[1] & samples[2]) |
		(samples[0] & samples[2]);
	assign split = (|samples) && !(&samples);

	assign last_data = (bit_idx == 3'd6 + {2'b00, cfg.data_bits});

	// write in the final cycle of the last stop bit
	assign wena = (state == STOP) && bit_end && (stop_idx || !cfg.stop_bits);

	always_comb begin
		// a 7-bit word sits in the upper bits of the shift register
		wword.data = cfg.data_bits ? shreg : shreg >> 1;
		wword.noise = noise_acc | split;
		wword.parity = parity_acc;
		wword.frame = frame_acc | !vote;
	end

	// samples at half a bit and half a bit plus and minus a sixteenth
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			samples <= 3'b111;
		end else if (state != IDLE) begin
			if (cnt == half - sixteenth)
				samples[0] <= rx_s;
			if (cnt == half)
				samples[1] <= rx_s;
			if (cnt == half + sixteenth)
				samples[2] <= rx_s;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
			bit_idx <= '0;
			stop_idx <= 1'b0;
			shreg <= '0;
			noise_acc <= 1'b0;
			parity_acc <= 1'b0;
			frame_acc <= 1'b0;
		end else if (clear) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			if (state != IDLE)
				cnt <= bit_end ? '0 : cnt + 24'd1;

			case (state)
				IDLE: begin
					if (!rx_s) begin
						// the detecting cycle already counts as part of the start bit
						state <= START;
						cnt <= 24'd1;
						bit_idx <= '0;
						stop_idx <= 1'b0;
						shreg <= '0;
						noise_acc <= 1'b0;
						parity_acc <= 1'b0;
						frame_acc <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						// a start bit that votes high was a glitch
						if (!vote) begin
							noise_acc <= split;
							state <= DATA;
						end else begin
							state <= IDLE;
						end
					end
				end
				DATA: begin
					if (bit_end) begin
						// lsb first
						shreg <= {vote, shreg[7:1]};
						noise_acc <= noise_acc | split;
						if (last_data)
							state <= cfg.parity ? PARITY : STOP;
						else
							bit_idx <= bit_idx + 3'd1;
					end
				end
				PARITY: begin
					if (bit_end) begin
						// even parity only
						noise_acc <= noise_acc | split;
						parity_acc <= (vote != ^shreg);
						state <= STOP;
					end
				end
				STOP: begin
					if (bit_end) begin
						noise_acc <= noise_acc | split;
						frame_acc <= frame_acc | !vote;
						if (wena)
							state <= IDLE;
						else
							stop_idx <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// word is dropped by the FIFO when full
	assign overflow = wena && full;
	assign rts = cfg.flow_ctrl && (size > RTS_LEVEL);

	fifo_buf #(
		.ADDR_W(FIFO_ADDR_W)
	) u_fifo_buf (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.wena(wena),
		.wdata(wword),
		.rena(rena),
		.rdata(head),
		.size(size),
		.empty(empty),
		.full(full)
	);

endmodule

// ==== uart_rx_drain.sv ====
`timescale 1ns/1ps

module uart_rx_drain import uart_line_pkg::*; import uart_rx_pkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	logic						hold,
	input	logic		[NUM_CHAN-1:0]	empty,
	input	rx_word_t	[NUM_CHAN-1:0]	head,
	input	logic		[NUM_CHAN-1:0]	overflow,
	output	logic		[NUM_CHAN-1:0]	rena,
	output	logic						out_valid,
	output	rx_rec_t					out_rec
);

	chan_id_t			last;
	chan_id_t			cand;
	chan_id_t			sel;
	logic				found;
	logic				take;
	logic [NUM_CHAN-1:0]	ovf_flags;
	logic [NUM_CHAN-1:0]	ovf_next;

	// rotating priority starting just after the last channel served
	always_comb begin
		found = 1'b0;
		sel = last;
		cand = last;
		for (int i = 1; i <= NUM_CHAN; i++) begin
			cand = last + chan_id_t'(i);
			if (!found && !empty[cand]) begin
				found = 1'b1;
				sel = cand;
			end
		end
	end

	assign take = found && !hold;

	always_comb begin
		rena = '0;
		rena[sel] = take;
	end

	// a new overflow in the read cycle stays pending for the next record
	always_comb begin
		ovf_next = ovf_flags;
		if (take)
			ovf_next[sel] = 1'b0;
		ovf_next = ovf_next | overflow;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			last <= chan_id_t'(NUM_CHAN - 1);
			out_valid <= 1'b0;
			ovf_flags <= '0;
		end else begin
			out_valid <= take;
			ovf_flags <= ovf_next;
			if (take)
				last <= sel;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			out_rec <= '{chan: sel, word: head[sel], overflow: ovf_flags[sel]};
	end

endmodule

// ==== uart_rx_hub.f ====
uart_line_pkg.sv
uart_rx_pkg.sv
fifo_buf.sv
uart_rx.sv
uart_line_cfg.sv
uart_rx_drain.sv
uart_rx_hub.sv
tb_uart_rx_hub.sv

// ==== uart_rx_hub.sv ====
`timescale 1ns/1ps

module uart_rx_hub import uart_line_pkg::*; import uart_rx_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					cfg_we,
	input	line_cfg_t				cfg_wdata,
	input	logic	[NUM_CHAN-1:0]	rx,
	output	logic	[NUM_CHAN-1:0]	rts,
	input	logic					hold,
	output	logic					out_valid,
	output	rx_rec_t				out_rec
);

	line_cfg_t				cfg;
	logic					clear;
	rx_word_t [NUM_CHAN-1:0]	head;
	logic [NUM_CHAN-1:0]	empty;
	logic [NUM_CHAN-1:0]	overflow;
	logic [NUM_CHAN-1:0]	rena;

	uart_line_cfg u_uart_line_cfg (
		.clk(clk),
		.reset(reset),
		.cfg_we(cfg_we),
		.cfg_wdata(cfg_wdata),
		.cfg(cfg),
		.clear(clear)
	);

	// all receivers run from the one shared setting
	for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
		uart_rx u_uart_rx (
			.clk(clk),
			.reset(reset),
			.clear(clear),
			.rx(rx[i]),
			.cfg(cfg),
			.rena(rena[i]),
			.head(head[i]),
			.empty(empty[i]),
			.rts(rts[i]),
			.overflow(overflow[i])
		);
	end

	uart_rx_drain u_uart_rx_drain (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.empty(empty),
		.head(head),
		.overflow(overflow),
		.rena(rena),
		.out_valid(out_valid),
		.out_rec(out_rec)
	);

endmodule

// ==== uart_rx_hub_testdata.txt ====
// setting(flow parity stop bits, divider)_ctrl(1 write, 2 random, 4 no frame)_mask_byte
// _fault(1 parity, 2 stop, 3 glitch)_hold_flags(4 noise, 2 parity, 1 frame)
// 8N1 on all channels at once
1000010_0_f_a5_0_0_0
1000010_2_f_00_0_0_0
1000010_2_f_00_0_0_0
// 7 data bits, even parity, two stop bits
6000014_2_f_00_0_0_0
6000014_0_5_c3_1_0_2
6000014_2_a_00_1_0_2
6000014_2_3_00_0_0_0
// low stop bit, then a glitch in a data bit
1000010_0_2_5a_2_0_1
1000010_0_8_3c_3_0_4
6000014_2_6_00_3_0_4
// flow control on, nine bytes on channel 2 under hold
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_2_4_00_0_1_0
9000010_4_0_00_0_0_0
// write under hold drops the queued bytes, divider 8 runs as 16
1000010_2_f_00_0_1_0
1000010_2_f_00_0_1_0
1000008_5_0_00_0_1_0
1000008_4_0_00_0_0_0
1000008_2_f_00_0_0_0
1000008_0_3_81_3_0_4

// ==== uart_rx_pkg.sv ====
package uart_rx_pkg;

	import uart_line_pkg::*;

	// 8 entries per channel FIFO
	localparam int FIFO_ADDR_W = 3;

	typedef logic [FIFO_ADDR_W:0] fill_t;

	// rts rises while more than this many words wait
	localparam fill_t RTS_LEVEL = 4'd4;

	typedef struct packed {
		logic [7:0]	data;
		logic		noise;
		logic		parity;
		logic		frame;
	} rx_word_t;

	typedef struct packed {
		chan_id_t	chan;
		rx_word_t	word;
		logic		overflow;
	} rx_rec_t;

endpackage
